// ==== all.f ====
src/pu_types_pkg.sv
src/pu_ctrl_pkg.sv
src/pu_if.sv
src/div_pipe.sv
src/pu_div.sv
src/pu_accum.sv
src/pu_ctrl.sv
src/pu_net.sv
sim/tb_pu_net.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_pu_net
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell cat all.f)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) all.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f all.f

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -qx 'TEST OK' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim/tb_pu_net.sv ====
module tb_pu_net import pu_types_pkg::*; import pu_ctrl_pkg::*; ();

  localparam int CLK_PERIOD = 20;
  localparam int RST_CYCLES = 8;
  localparam int DRIVE_DLY  = 2;
  localparam int NUM_CMDS   = 200;
  localparam int MAX_GAP    = 15;  // Gaps shorter than a command keep cmd_valid high while busy
  localparam int TIMEOUT    = NUM_CMDS * (5 + DIV_WAIT + MAX_GAP) * CLK_PERIOD
                            + RST_CYCLES * CLK_PERIOD;

  logic  clk;
  logic  rst;
  logic  cmd_valid;
  op_t   cmd_op;
  data_t cmd_a;
  data_t cmd_b;
  logic  cmd_ready;
  logic  res_valid;
  data_t res_lo;
  data_t res_hi;
  attr_t res_attr;

  integer seed;
  int     errors       = 0;
  int     tx_count     = 0;
  int     rx_count     = 0;
  int     cycle        = 0;
  logic   busy         = 1'b0;
  logic   idle_checked = 1'b0;
  data_t  exp_lo_q[$];
  data_t  exp_hi_q[$];
  attr_t  exp_attr_q[$];
  int     due_q[$];  // Cycle in which res_valid must show up

  pu_net i_pu_net (
    .clk       (clk),
    .rst       (rst),
    .cmd_valid (cmd_valid),
    .cmd_op    (cmd_op),
    .cmd_a     (cmd_a),
    .cmd_b     (cmd_b),
    .cmd_ready (cmd_ready),
    .res_valid (res_valid),
    .res_lo    (res_lo),
    .res_hi    (res_hi),
    .res_attr  (res_attr)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic report_mismatch(input string name, input data_t exp_v, input data_t act_v);
    $display("ERROR %s expected 0x%0h got 0x%0h", name, exp_v, act_v);
    errors++;
  endtask

  // Reference model of one command
  task automatic predict(input op_t op, input data_t a, input data_t b,
                         output data_t lo, output data_t hi, output attr_t attr);
    logic [DATA_WIDTH:0] wide;
    attr = '0;
    hi   = '0;
    case (op)
      OP_DIV: begin
        if (b == '0) begin
          lo = '1;
          hi = a;
          attr[ATTR_INVALID] = 1'b1;
        end else begin
          lo = a / b;
          hi = a % b;
        end
      end
      OP_ADD: begin
        wide = {1'b0, a} + {1'b0, b};
        lo   = wide[DATA_WIDTH-1:0];
        attr[ATTR_CARRY] = wide[DATA_WIDTH];
      end
      default: begin
        lo = a - b;
        attr[ATTR_CARRY] = (b > a);  // Borrow
      end
    endcase
  endtask

  task automatic make_command(output op_t op, output data_t a, output data_t b,
                              output int unsigned gap);
    int unsigned kind;
    int unsigned sel;
    int unsigned shift;
    kind  = {$random(seed)} % 8;
    sel   = {$random(seed)} % 3;
    shift = {$random(seed)} % 32;
    op = (sel == 0) ? OP_DIV : ((sel == 1) ? OP_ADD : OP_SUB);
    a  = $random(seed);
    b  = data_t'($random(seed)) >> shift;  // Spreads quotient sizes
    if (kind == 0) begin
      b = '0;
    end else if (kind == 1) begin
      if ({$random(seed)} % 2 == 0) begin
        a = {$random(seed)} % 256;
        b = {$random(seed)} % 256;
      end else begin
        a = '1;
        b = ({$random(seed)} % 2 == 0) ? '1 : b;
      end
    end
    gap = {$random(seed)} % (MAX_GAP + 1);
  endtask

  // Outputs are sampled mid-cycle
  always @(negedge clk) begin : monitor
    data_t e_lo;
    data_t e_hi;
    attr_t e_attr;
    int    due;
    cycle = cycle + 1;
    if (!rst) begin
      if (!idle_checked) begin
        idle_checked = 1'b1;
        if (cmd_ready !== 1'b1) report_mismatch("cmd_ready", 32'd1, data_t'(cmd_ready));
        if (res_valid !== 1'b0) report_mismatch("res_valid", 32'd0, data_t'(res_valid));
      end
      if (res_valid === 1'b1) begin
        if (due_q.size() == 0) begin
          $display("A result arrived with no command outstanding");
          errors++;
        end else begin
          e_lo   = exp_lo_q.pop_front();
          e_hi   = exp_hi_q.pop_front();
          e_attr = exp_attr_q.pop_front();
          due    = due_q.pop_front();
          if (res_lo !== e_lo) report_mismatch("res_lo", e_lo, res_lo);
          if (res_hi !== e_hi) report_mismatch("res_hi", e_hi, res_hi);
          if (res_attr !== e_attr) report_mismatch("res_attr", data_t'(e_attr), data_t'(res_attr));
          if (cycle != due) report_mismatch("res_valid cycle", data_t'(due), data_t'(cycle));
        end
        if (cmd_ready !== 1'b0) report_mismatch("cmd_ready", 32'd0, data_t'(cmd_ready));
        rx_count++;
        busy = 1'b0;
      end else if (busy && cmd_ready !== 1'b0) begin
        $display("cmd_ready rose before the result of the last command");
        errors++;
      end
      if (cmd_valid && cmd_ready === 1'b1) begin
        predict(cmd_op, cmd_a, cmd_b, e_lo, e_hi, e_attr);
        exp_lo_q.push_back(e_lo);
        exp_hi_q.push_back(e_hi);
        exp_attr_q.push_back(e_attr);
        due_q.push_back(cycle + 5 + ((cmd_op == OP_DIV) ? DIV_WAIT : ACC_WAIT));
        tx_count++;
        busy = 1'b1;
      end
    end
  end

  initial begin
    op_t         op;
    data_t       a;
    data_t       b;
    int unsigned gap;
    logic        took;
    int          end_errors;
    end_errors = 0;
    seed       = 1;
    rst        = 1'b1;
    cmd_valid  = 1'b0;
    cmd_op     = OP_DIV;
    cmd_a      = '0;
    cmd_b      = '0;
    repeat (RST_CYCLES) @(posedge clk);
    #(DRIVE_DLY);
    rst = 1'b0;
    for (int i = 0; i < NUM_CMDS; i++) begin
      make_command(op, a, b, gap);
      if (gap != 0) begin
        cmd_valid = 1'b0;
        repeat (gap) @(posedge clk);
        #(DRIVE_DLY);
      end
      cmd_valid = 1'b1;
      cmd_op    = op;
      cmd_a     = a;
      cmd_b     = b;
      do begin
        @(negedge clk);
        took = cmd_ready;
        @(posedge clk);
        #(DRIVE_DLY);
      end while (!took);
    end
    cmd_valid = 1'b0;
    wait (rx_count == NUM_CMDS);
    repeat (4 * (5 + DIV_WAIT)) @(posedge clk);  // Room for a stray extra result
    if (rx_count != NUM_CMDS) begin
      $display("More results arrived than commands were sent");
      end_errors++;
    end
    $display("errors=%0d accepted=%0d results=%0d", errors + end_errors, tx_count, rx_count);
    if (errors + end_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT);
    $display("Timeout, the results did not arrive in time");
    $display("errors=%0d accepted=%0d results=%0d", errors, tx_count, rx_count);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== src/pu_net.sv ====
module pu_net import pu_types_pkg::*; import pu_ctrl_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  cmd_valid,
  input  op_t   cmd_op,
  input  data_t cmd_a,
  input  data_t cmd_b,
  output logic  cmd_ready,
  output logic  res_valid,
  output data_t res_lo,
  output data_t res_hi,
  output attr_t res_attr
);

  pu_if div_bus ();
  pu_if acc_bus ();

  pu_ctrl i_pu_ctrl (
    .clk       (clk),
    .rst       (rst),
    .cmd_valid (cmd_valid),
    .cmd_op    (cmd_op),
    .cmd_a     (cmd_a),
    .cmd_b     (cmd_b),
    .cmd_ready (cmd_ready),
    .res_valid (res_valid),
    .res_lo    (res_lo),
    .res_hi    (res_hi),
    .res_attr  (res_attr),
    .div_port  (div_bus),
    .acc_port  (acc_bus)
  );

  pu_div i_pu_div (
    .clk  (clk),
    .rst  (rst),
    .port (div_bus)
  );

  pu_accum i_pu_accum (
    .clk  (clk),
    .rst  (rst),
    .port (acc_bus)
  );

endmodule

// ==== src/pu_ctrl.sv ====
module pu_ctrl import pu_types_pkg::*; import pu_ctrl_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  cmd_valid,
  input  op_t   cmd_op,
  input  data_t cmd_a,
  input  data_t cmd_b,
  output logic  cmd_ready,
  output logic  res_valid,
  output data_t res_lo,
  output data_t res_hi,
  output attr_t res_attr,
  pu_if.ctrl    div_port,
  pu_if.ctrl    acc_port
);

  ctrl_state_t           state;
  op_t                   op_q;
  data_t                 a_q;
  data_t                 b_q;
  logic [WAIT_CNT_W-1:0] wait_cnt;
  attr_t                 attr_lo;
  logic                  is_div;
  logic                  wr;
  logic                  oe;
  data_t                 bus_data;
  attr_t                 bus_attr;
  attr_t                 wr_attr;

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= IDLE;
      op_q      <= OP_DIV;
      wait_cnt  <= '0;
      res_valid <= 1'b0;
    end else begin
      res_valid <= (state == RD_HI);
      case (state)
        IDLE: begin
          if (cmd_valid) begin
            op_q  <= cmd_op;
            state <= WR_A;
          end
        end
        WR_A: state <= WR_B;
        WR_B: begin
          wait_cnt <= (op_q == OP_DIV) ? WAIT_CNT_W'(DIV_WAIT - 1) : WAIT_CNT_W'(ACC_WAIT - 1);
          state    <= WAIT;
        end
        WAIT: begin
          if (wait_cnt == '0) begin
            state <= RD_LO;
          end else begin
            wait_cnt <= wait_cnt - 1'b1;
          end
        end
        RD_LO: state <= RD_HI;
        RD_HI: state <= DONE;
        default: state <= IDLE;  // DONE
      endcase
    end
  end

  // Operands and results
  always_ff @(posedge clk) begin
    if (state == IDLE && cmd_valid) begin
      a_q <= cmd_a;
      b_q <= cmd_b;
    end
    if (state == RD_LO) begin
      res_lo  <= bus_data;
      attr_lo <= bus_attr;
    end
    if (state == RD_HI) begin
      res_hi   <= bus_data;
      res_attr <= attr_lo | bus_attr;
    end
  end

  assign cmd_ready = (state == IDLE);
  assign is_div    = (op_q == OP_DIV);
  assign wr        = (state == WR_A) || (state == WR_B);
  assign oe        = (state == RD_LO) || (state == RD_HI);

  always_comb begin
    wr_attr = '0;
    wr_attr[ATTR_NEG] = (state == WR_B) && (op_q == OP_SUB);
  end

  assign div_port.wr      = wr && is_div;
  assign div_port.wr_sel  = (state == WR_B);
  assign div_port.oe      = oe && is_div;
  assign div_port.oe_sel  = (state == RD_HI);
  assign div_port.data_in = (state == WR_A) ? a_q : b_q;
  assign div_port.attr_in = '0;

  assign acc_port.wr      = wr && !is_div;
  assign acc_port.wr_sel  = (state == WR_B);
  assign acc_port.oe      = oe && !is_div;
  assign acc_port.oe_sel  = (state == RD_HI);
  assign acc_port.data_in = (state == WR_A) ? a_q : b_q;
  assign acc_port.attr_in = wr_attr;

  // Idle units drive zero
  assign bus_data = div_port.data_out | acc_port.data_out;
  assign bus_attr = div_port.attr_out | acc_port.attr_out;

  a_one_reader: assert property (@(posedge clk) disable iff (rst)
    !(div_port.oe && acc_port.oe));

  a_div_wr_oe: assert property (@(posedge clk) disable iff (rst)
    !(div_port.wr && div_port.oe));

  a_acc_wr_oe: assert property (@(posedge clk) disable iff (rst)
    !(acc_port.wr && acc_port.oe));

  a_valid_in_done: assert property (@(posedge clk) disable iff (rst)
    res_valid |-> state == DONE);

endmodule

// ==== src/pu_accum.sv ====
module pu_accum import pu_types_pkg::*; (
  input  logic clk,
  input  logic rst,
  pu_if.pu     port
);

  data_t             opnd_q;
  logic              inv_latch;
  logic [DATA_WIDTH:0] sum_q;  // Top bit is carry or borrow
  logic              inv_q;
  attr_t             attr_res;

  always_ff @(posedge clk) begin
    if (rst) begin
      opnd_q    <= '0;
      inv_latch <= 1'b0;
      sum_q     <= '0;
      inv_q     <= 1'b0;
    end else if (port.wr) begin
      if (!port.wr_sel) begin
        opnd_q    <= port.data_in;
        inv_latch <= port.attr_in[ATTR_INVALID];
      end else begin
        if (port.attr_in[ATTR_NEG]) begin
          sum_q <= {1'b0, opnd_q} - {1'b0, port.data_in};
        end else begin
          sum_q <= {1'b0, opnd_q} + {1'b0, port.data_in};
        end
        inv_q <= inv_latch | port.attr_in[ATTR_INVALID];
      end
    end
  end

  always_comb begin
    attr_res = '0;
    attr_res[ATTR_CARRY]   = sum_q[DATA_WIDTH];
    attr_res[ATTR_INVALID] = inv_q;
  end

  // No high word, only the attribute on the second read
  assign port.data_out = (port.oe && !port.oe_sel) ? sum_q[DATA_WIDTH-1:0] : '0;
  assign port.attr_out = port.oe ? attr_res : '0;

endmodule

// ==== src/pu_div.sv ====
module pu_div import pu_types_pkg::*; (
  input  logic clk,
  input  logic rst,
  pu_if.pu     port
);

  data_t                 numer_latch;
  logic                  inv_latch;
  data_t                 numer_q;
  data_t                 denom_q;
  logic                  inv_arg_q;
  logic [DIV_STAGES-1:0] inv_pipe;   // Follows the division through div_pipe
  data_t                 quo_pipe;
  data_t                 rem_pipe;
  data_t                 quo_q;
  data_t                 rem_q;
  logic                  inv_q;
  attr_t                 attr_res;

  always_ff @(posedge clk) begin
    if (rst) begin
      numer_latch <= '0;
      inv_latch   <= 1'b0;
      numer_q     <= '0;
      denom_q     <= '0;
      inv_arg_q   <= 1'b0;
    end else if (port.wr) begin
      if (!port.wr_sel) begin
        numer_latch <= port.data_in;
        inv_latch   <= port.attr_in[ATTR_INVALID];
      end else begin
        numer_q   <= numer_latch;  // Launch
        denom_q   <= port.data_in;
        inv_arg_q <= inv_latch | port.attr_in[ATTR_INVALID];
      end
    end
  end

  div_pipe i_div_pipe (
    .clk      (clk),
    .rst      (rst),
    .numer    (numer_q),
    .denom    (denom_q),
    .quotient (quo_pipe),
    .remain   (rem_pipe)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      inv_pipe <= '0;
      quo_q    <= '0;
      rem_q    <= '0;
      inv_q    <= 1'b0;
    end else begin
      inv_pipe <= {inv_pipe[DIV_STAGES-2:0], inv_arg_q | (denom_q == '0)};
      quo_q    <= quo_pipe;
      rem_q    <= rem_pipe;
      inv_q    <= inv_pipe[DIV_STAGES-1];
    end
  end

  always_comb begin
    attr_res = '0;
    attr_res[ATTR_INVALID] = inv_q;
  end

  assign port.data_out = port.oe ? (port.oe_sel ? rem_q : quo_q) : '0;
  assign port.attr_out = port.oe ? attr_res : '0;

  // Reading too early would return the previous division
  a_no_early_read: assert property (@(posedge clk) disable iff (rst)
    (port.wr && port.wr_sel) |=> !port.oe [*DIV_STAGES]);

endmodule

// ==== src/div_pipe.sv ====
module div_pipe import pu_types_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  data_t numer,
  input  data_t denom,
  output data_t quotient,
  output data_t remain
);

  localparam int BITS = DATA_WIDTH / DIV_STAGES;  // Quotient bits per stage

  typedef struct packed {
    data_t rem;
    data_t quo;
    data_t num;  // Numerator bits not yet shifted in
    data_t den;
  } stage_t;

  stage_t st_q [DIV_STAGES];

  // A zero denominator always passes the trial subtraction, so the quotient
  // fills with ones and the numerator ends up in the remainder
  for (genvar s = 0; s < DIV_STAGES; s++) begin : g_stage
    stage_t cur;
    stage_t nxt;

    if (s == 0) begin : g_first
      assign cur = '{rem: '0, quo: '0, num: numer, den: denom};
    end else begin : g_next
      assign cur = st_q[s-1];
    end

    always_comb begin
      logic [DATA_WIDTH:0] trial;
      nxt = cur;
      for (int b = 0; b < BITS; b++) begin
        trial = {nxt.rem, nxt.num[DATA_WIDTH-1]};
        nxt.num = nxt.num << 1;
        if (trial >= {1'b0, nxt.den}) begin
          trial = trial - {1'b0, nxt.den};
          nxt.quo = {nxt.quo[DATA_WIDTH-2:0], 1'b1};
        end else begin
          nxt.quo = {nxt.quo[DATA_WIDTH-2:0], 1'b0};
        end
        nxt.rem = trial[DATA_WIDTH-1:0];
      end
    end

    always_ff @(posedge clk) begin
      if (rst) begin
        st_q[s] <= '0;
      end else begin
        st_q[s] <= nxt;
      end
    end
  end

  assign quotient = st_q[DIV_STAGES-1].quo;
  assign remain   = st_q[DIV_STAGES-1].rem;

endmodule

// ==== src/pu_if.sv ====
interface pu_if import pu_types_pkg::*; ();

  logic  wr;
  logic  wr_sel;    // High on the launch write
  logic  oe;
  logic  oe_sel;    // Low word or high word
  data_t data_in;
  attr_t attr_in;
  data_t data_out;  // Zero while oe is low
  attr_t attr_out;

  modport ctrl (
    output wr, wr_sel, oe, oe_sel, data_in, attr_in,
    input  data_out, attr_out
  );

  modport pu (
    input  wr, wr_sel, oe, oe_sel, data_in, attr_in,
    output data_out, attr_out
  );

endinterface

// ==== src/pu_ctrl_pkg.sv ====
package pu_ctrl_pkg;

  typedef enum logic [1:0] {
    OP_DIV = 2'd0,
    OP_ADD = 2'd1,
    OP_SUB = 2'd2
  } op_t;

  typedef enum logic [2:0] {
    IDLE  = 3'd0,
    WR_A  = 3'd1,
    WR_B  = 3'd2,
    WAIT  = 3'd3,
    RD_LO = 3'd4,
    RD_HI = 3'd5,
    DONE  = 3'd6
  } ctrl_state_t;

  // Divider pipe plus the unit's output register
  localparam int DIV_WAIT = pu_types_pkg::DIV_STAGES + 1;
  localparam int ACC_WAIT = 1;

  localparam int WAIT_CNT_W = $clog2(DIV_WAIT + 1);

endpackage

// ==== src/pu_types_pkg.sv ====
package pu_types_pkg;

  localparam int DATA_WIDTH = 32;
  localparam int ATTR_WIDTH = 4;

  localparam int ATTR_INVALID = 0;  // Result not usable
  localparam int ATTR_CARRY   = 1;  // Carry or borrow out of the accumulator
  localparam int ATTR_NEG     = 2;  // Accumulator subtracts on launch

  // Register stages inside div_pipe
  localparam int DIV_STAGES = 4;

  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [ATTR_WIDTH-1:0] attr_t;

endpackage
